// ==== rvPkg.sv ====
package rvPkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word views
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFieldsT;

	typedef struct packed {
		logic [19:0] raw;    // Word bits 31 to 12
		logic [4:0]  rd;     // Low immediate bits of S and B
		logic [6:0]  opcode;
	} immFieldsT;

	typedef union packed {
		rFieldsT   rView;   // Register and funct fields
		immFieldsT immView; // Immediate slicing
	} rvInstrT;

	////////////////////////////////////////////////////////////////////////////
	// Datapath codes
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluSll  = 4'd2,
		aluSlt  = 4'd3,
		aluSltu = 4'd4,
		aluXor  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluOr   = 4'd8,
		aluAnd  = 4'd9
	} aluOpT;

	typedef enum logic [2:0] {
		immISext = 3'd0, // I format, sign extended
		immIZext = 3'd1, // I format, zero extended
		immS     = 3'd2,
		immB     = 3'd3,
		immU     = 3'd4,
		immJ     = 3'd5
	} immKindT;

	typedef logic [2:0] memWidthT; // Same code as load/store funct3
	localparam memWidthT memByte  = 3'd0;
	localparam memWidthT memHalf  = 3'd1;
	localparam memWidthT memWord  = 3'd2;
	localparam memWidthT memByteU = 3'd4;
	localparam memWidthT memHalfU = 3'd5;

	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;

endpackage

// ==== controlUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
	input  rvPkg::rvInstrT  instr,
	output rvPkg::aluOpT    aluOp,
	output rvPkg::immKindT  immKind,
	output rvPkg::memWidthT memWidth,
	output logic            immSel,      // ALU operand B from immediate
	output logic            setDataZero, // Operand A forced to zero
	output logic            regWrite,
	output logic            memRead,
	output logic            memWrite,
	output logic            branch,
	output logic            pcOperand,   // Operand A from PC
	output logic            jump,
	output logic            linkPc4      // Writeback PC+4
);
	import rvPkg::*;

	aluOpT fnOp; // Op picked by funct3 and funct7

	always_comb begin
		case (instr.rView.funct3)
			3'b000: begin
				if (instr.rView.funct7 == 7'b0100000 && instr.rView.opcode == opReg)
					fnOp = aluSub; // SUB only in register form
				else
					fnOp = aluAdd;
			end
			3'b001: fnOp = aluSll;
			3'b010: fnOp = aluSlt;
			3'b011: fnOp = aluSltu;
			3'b100: fnOp = aluXor;
			3'b101: begin
				if (instr.rView.funct7 == 7'b0100000)
					fnOp = aluSra; // SRA and SRAI
				else
					fnOp = aluSrl;
			end
			3'b110: fnOp = aluOr;
			default: fnOp = aluAnd;
		endcase
	end

	always_comb begin
		aluOp       = aluAdd; // Address and link math all add
		immKind     = immISext;
		memWidth    = memByte;
		immSel      = 1'b0;
		setDataZero = 1'b0;
		regWrite    = 1'b0; // Unknown opcodes stay silent
		memRead     = 1'b0;
		memWrite    = 1'b0;
		branch      = 1'b0;
		pcOperand   = 1'b0;
		jump        = 1'b0;
		linkPc4     = 1'b0;
		case (instr.rView.opcode)
			opLui: begin
				setDataZero = 1'b1; // 0 + imm
				immSel      = 1'b1;
				immKind     = immU;
				regWrite    = 1'b1;
			end
			opAuipc: begin
				immSel    = 1'b1;
				immKind   = immU;
				regWrite  = 1'b1;
				pcOperand = 1'b1; // PC + imm
			end
			opJal: begin
				immSel    = 1'b1;
				immKind   = immJ;
				regWrite  = 1'b1;
				pcOperand = 1'b1;
				jump      = 1'b1;
				linkPc4   = 1'b1;
			end
			opJalr: begin
				immSel    = 1'b1;
				regWrite  = 1'b1;
				pcOperand = 1'b1;
				jump      = 1'b1;
				linkPc4   = 1'b1;
			end
			opBranch: begin
				branch  = 1'b1;
				immSel  = 1'b1;
				immKind = immB;
			end
			opLoad: begin
				immSel   = 1'b1;
				regWrite = 1'b1;
				memRead  = 1'b1;
				memWidth = instr.rView.funct3;
			end
			opStore: begin
				immSel   = 1'b1;
				immKind  = immS;
				memWrite = 1'b1;
				memWidth = instr.rView.funct3;
			end
			opImm: begin
				immSel   = 1'b1;
				regWrite = 1'b1;
				aluOp    = fnOp;
			end
			opReg: begin
				regWrite = 1'b1;
				aluOp    = fnOp;
			end
			default: regWrite = 1'b0; // FENCE, SYSTEM and the rest
		endcase
	end

endmodule

`default_nettype wire

// ==== immGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module immGen (
	input  rvPkg::rvInstrT  instr,
	input  rvPkg::immKindT  immKind,
	output logic [31:0]     imm
);
	import rvPkg::*;

	logic [19:0] raw; // Word bits 31 to 12
	logic [4:0]  low; // Word bits 11 to 7

	assign raw = instr.immView.raw;
	assign low = instr.immView.rd;

	always_comb begin
		case (immKind)
			immISext: imm = {{20{raw[19]}}, raw[19:8]};
			immIZext: imm = {20'd0, raw[19:8]};
			immS:     imm = {{20{raw[19]}}, raw[19:13], low};
			immB:     imm = {{19{raw[19]}}, raw[19], low[0], raw[18:13], low[4:1], 1'b0};
			immU:     imm = {raw, 12'd0};
			immJ:     imm = {{11{raw[19]}}, raw[19], raw[7:0], raw[8], raw[18:9], 1'b0};
			default:  imm = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

// ==== execUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module execUnit (
	input  logic            clk,
	input  logic            rstN,
	input  logic            instrValid,
	input  rvPkg::rvInstrT  instr,
	output logic            instrReady,
	input  rvPkg::aluOpT    aluOp,
	input  rvPkg::immKindT  immKind,
	input  rvPkg::memWidthT memWidth,
	input  logic            immSel,
	input  logic            setDataZero,
	input  logic            regWrite,
	input  logic            memRead,
	input  logic            memWrite,
	input  logic            branch,
	input  logic            pcOperand,
	input  logic            jump,
	input  logic            linkPc4,
	input  logic [31:0]     imm,
	input  logic [31:0]     pc,
	output logic            nextPcValid,
	output logic [31:0]     nextPc,
	output logic            lsuValid,
	output logic            lsuWrite,
	output rvPkg::memWidthT lsuWidth,
	output logic [31:0]     lsuAddr,
	output logic [31:0]     lsuWdata,
	input  logic            lsuReady,
	input  logic            lsuDone,
	input  logic [31:0]     lsuRdata
);
	import rvPkg::*;

	localparam logic [1:0] sIdle    = 2'd0;
	localparam logic [1:0] sExec    = 2'd1;
	localparam logic [1:0] sMemWait = 2'd2;
	localparam logic [1:0] sRetire  = 2'd3;

	logic [1:0]  state;
	logic [31:0] regs [32]; // x0 never written
	logic [31:0] rs1Val;
	logic [31:0] rs2Val;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [31:0] aluRes;
	logic [31:0] pcPlus4;
	logic [31:0] targetSum;
	logic [31:0] loadData; // Held from lsuDone to retire
	logic [31:0] wbData;
	logic        memOp;
	logic        taken;
	logic        wbEn;

	assign rs1Val = regs[instr.rView.rs1];
	assign rs2Val = regs[instr.rView.rs2];
	assign memOp  = memRead | memWrite;
	assign opA    = setDataZero ? 32'd0 : (pcOperand ? pc : rs1Val); // LUI takes zero
	assign opB    = immSel ? imm : rs2Val;

	////////////////////////////////////////////////////////////////////////////
	// ALU and branch compare
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (aluOp)
			aluSub:  aluRes = opA - opB;
			aluSll:  aluRes = opA << opB[4:0];
			aluSlt:  aluRes = {31'd0, $signed(opA) < $signed(opB)};
			aluSltu: aluRes = {31'd0, opA < opB};
			aluXor:  aluRes = opA ^ opB;
			aluSrl:  aluRes = opA >> opB[4:0];
			aluSra:  aluRes = $unsigned($signed(opA) >>> opB[4:0]);
			aluOr:   aluRes = opA | opB;
			aluAnd:  aluRes = opA & opB;
			default: aluRes = opA + opB; // ADD, loads, stores
		endcase
	end

	always_comb begin
		case (instr.rView.funct3)
			3'b000:  taken = rs1Val == rs2Val;                   // BEQ
			3'b001:  taken = rs1Val != rs2Val;                   // BNE
			3'b100:  taken = $signed(rs1Val) < $signed(rs2Val);  // BLT
			3'b101:  taken = $signed(rs1Val) >= $signed(rs2Val); // BGE
			3'b110:  taken = rs1Val < rs2Val;                    // BLTU
			3'b111:  taken = rs1Val >= rs2Val;                   // BGEU
			default: taken = 1'b0;
		endcase
	end

	assign pcPlus4   = pc + 32'd4;
	assign targetSum = ((jump && immKind != immJ) ? rs1Val : pc) + imm; // JALR base is rs1
	assign nextPc    = (jump || (branch && taken)) ? {targetSum[31:1], 1'b0} : pcPlus4;

	assign wbData      = linkPc4 ? pcPlus4 : (memRead ? loadData : aluRes);
	assign nextPcValid = (state == sExec && !memOp) || state == sRetire;
	assign wbEn        = nextPcValid && regWrite && instr.rView.rd != 5'd0;
	assign instrReady  = state == sIdle;
	assign lsuValid    = state == sExec && memOp;
	assign lsuWrite    = memWrite;
	assign lsuWidth    = memWidth;
	assign lsuAddr     = aluRes; // rs1 + imm
	assign lsuWdata    = rs2Val;

	////////////////////////////////////////////////////////////////////////////
	// Sequencing and register file
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state    <= sIdle;
			loadData <= 32'd0;
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else begin
			if (wbEn)
				regs[instr.rView.rd] <= wbData;
			case (state)
				sIdle: if (instrValid) state <= sExec;
				sExec: begin
					if (!memOp)
						state <= sIdle; // Retired this cycle
					else if (lsuReady)
						state <= sMemWait;
				end
				sMemWait: begin
					if (lsuDone) begin
						loadData <= lsuRdata;
						state    <= sRetire;
					end
				end
				default: state <= sIdle; // Retire
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== fetchUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchUnit #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input  logic        clk,
	input  logic        rstN,
	output logic        fetchValid,
	output logic [31:0] fetchAddr,
	input  logic        fetchReady,
	input  logic        fetchRvalid,
	input  logic [31:0] fetchRdata,
	output logic        instrValid,
	output logic [31:0] instr, // Stable until the next word lands
	input  logic        instrReady,
	output logic [31:0] pc,
	input  logic        nextPcValid,
	input  logic [31:0] nextPc
);
	localparam logic [2:0] sBoot   = 3'd0; // One quiet cycle out of reset
	localparam logic [2:0] sReq    = 3'd1;
	localparam logic [2:0] sResp   = 3'd2;
	localparam logic [2:0] sOffer  = 3'd3;
	localparam logic [2:0] sWaitPc = 3'd4;

	logic [2:0] state;

	assign fetchValid = state == sReq;
	assign fetchAddr  = pc;
	assign instrValid = state == sOffer;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= sBoot;
			pc    <= resetPc;
			instr <= 32'd0;
		end else begin
			case (state)
				sBoot: state <= sReq;
				sReq:  if (fetchReady) state <= sResp;
				sResp: begin
					if (fetchRvalid) begin
						instr <= fetchRdata;
						state <= sOffer;
					end
				end
				sOffer: if (instrReady) state <= sWaitPc;
				sWaitPc: begin
					if (nextPcValid) begin
						pc    <= nextPc; // Retire hands back the PC
						state <= sReq;
					end
				end
				default: state <= sBoot;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== loadStoreUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module loadStoreUnit (
	input  logic            clk,
	input  logic            rstN,
	input  logic            lsuValid,
	input  logic            lsuWrite,
	input  rvPkg::memWidthT lsuWidth,
	input  logic [31:0]     lsuAddr,
	input  logic [31:0]     lsuWdata,
	output logic            lsuReady,
	output logic            lsuDone,
	output logic [31:0]     lsuRdata,
	output logic            dataValid,
	output logic            dataWrite,
	output logic [31:0]     dataAddr,
	output logic [31:0]     dataWdata,
	output logic [3:0]      dataStrb,
	input  logic            dataReady,
	input  logic            dataRvalid,
	input  logic [31:0]     dataRdata
);
	import rvPkg::*;

	localparam logic [1:0] sIdle = 2'd0;
	localparam logic [1:0] sReq  = 2'd1;
	localparam logic [1:0] sWait = 2'd2;

	logic [1:0]  state;
	logic        writeQ;
	memWidthT    widthQ;
	logic [31:0] addrQ;
	logic [31:0] wdataQ;
	logic [31:0] shifted; // Addressed lane moved to bit 0

	assign lsuReady  = state == sIdle;
	assign lsuDone   = state == sWait && dataRvalid;
	assign dataValid = state == sReq;
	assign dataWrite = writeQ;
	assign dataAddr  = {addrQ[31:2], 2'b00};
	assign shifted   = dataRdata >> {addrQ[1:0], 3'b000};

	always_comb begin
		case (widthQ)
			memByte: begin
				dataWdata = {4{wdataQ[7:0]}};
				dataStrb  = 4'b0001 << addrQ[1:0];
			end
			memHalf: begin
				dataWdata = {2{wdataQ[15:0]}};
				dataStrb  = 4'b0011 << {addrQ[1], 1'b0};
			end
			memWord: begin
				dataWdata = wdataQ;
				dataStrb  = 4'b1111;
			end
			default: begin
				dataWdata = wdataQ;
				dataStrb  = 4'b0000; // No lanes for bad widths
			end
		endcase
	end

	always_comb begin
		case (widthQ)
			memByte:  lsuRdata = {{24{shifted[7]}}, shifted[7:0]};
			memHalf:  lsuRdata = {{16{shifted[15]}}, shifted[15:0]};
			memByteU: lsuRdata = {24'd0, shifted[7:0]};
			memHalfU: lsuRdata = {16'd0, shifted[15:0]};
			default:  lsuRdata = shifted;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state  <= sIdle;
			writeQ <= 1'b0;
			widthQ <= memByte;
			addrQ  <= 32'd0;
			wdataQ <= 32'd0;
		end else begin
			case (state)
				sIdle: begin
					if (lsuValid) begin
						writeQ <= lsuWrite;
						widthQ <= lsuWidth;
						addrQ  <= lsuAddr;
						wdataQ <= lsuWdata;
						state  <= sReq;
					end
				end
				sReq:  if (dataReady) state <= sWait;
				sWait: if (dataRvalid) state <= sIdle; // lsuDone this cycle
				default: state <= sIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== memArbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module memArbiter (
	input  logic        clk,
	input  logic        rstN,
	input  logic        fetchValid,
	input  logic [31:0] fetchAddr,
	output logic        fetchReady,
	output logic        fetchRvalid,
	output logic [31:0] fetchRdata,
	input  logic        dataValid,
	input  logic        dataWrite,
	input  logic [31:0] dataAddr,
	input  logic [31:0] dataWdata,
	input  logic [3:0]  dataStrb,
	output logic        dataReady,
	output logic        dataRvalid,
	output logic [31:0] dataRdata,
	output logic        memValid,
	output logic        memWrite,
	output logic [31:0] memAddr,
	output logic [31:0] memWdata,
	output logic [3:0]  memStrb,
	input  logic        memReady,
	input  logic        memRvalid,
	input  logic [31:0] memRdata
);
	logic busy;      // Request accepted, response pending
	logic ownerData; // Who gets the response
	logic lockFetch; // Fetch on the bus, still waiting
	logic selData;

	assign selData  = dataValid && !lockFetch; // Data first
	assign memValid = !busy && (dataValid || fetchValid);
	assign memWrite = selData && dataWrite;
	assign memAddr  = selData ? dataAddr : fetchAddr;
	assign memWdata = selData ? dataWdata : 32'd0;
	assign memStrb  = selData ? dataStrb : 4'd0;

	assign dataReady   = !busy && selData && memReady;
	assign fetchReady  = !busy && !selData && memReady;
	assign dataRvalid  = busy && ownerData && memRvalid;
	assign fetchRvalid = busy && !ownerData && memRvalid;
	assign dataRdata   = memRdata;
	assign fetchRdata  = memRdata;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy      <= 1'b0;
			ownerData <= 1'b0;
			lockFetch <= 1'b0;
		end else if (!busy) begin
			lockFetch <= memValid && !memReady && !selData; // Keep fields steady
			if (memValid && memReady) begin
				busy      <= 1'b1;
				ownerData <= selData;
			end
		end else if (memRvalid) begin
			busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rvCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module rvCore #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input  logic        clk,
	input  logic        rstN,
	output logic        memValid,
	output logic        memWrite,
	output logic [31:0] memAddr,
	output logic [31:0] memWdata,
	output logic [3:0]  memStrb,
	input  logic        memReady,
	input  logic        memRvalid,
	input  logic [31:0] memRdata
);
	import rvPkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////////////////////////////////////////
	logic        fetchValid;
	logic        fetchReady;
	logic        fetchRvalid;
	logic [31:0] fetchAddr;
	logic [31:0] fetchRdata;
	logic        instrValid;
	logic        instrReady;
	rvInstrT     instr;
	logic [31:0] pc;
	logic        nextPcValid;
	logic [31:0] nextPc;
	aluOpT       aluOp;
	immKindT     immKind;
	memWidthT    memWidth;
	logic        immSel;
	logic        setDataZero;
	logic        regWrite;
	logic        memRead;
	logic        memWriteOp; // Store decoded, not the bus write
	logic        branch;
	logic        pcOperand;
	logic        jump;
	logic        linkPc4;
	logic [31:0] imm;
	logic        lsuValid;
	logic        lsuReady;
	logic        lsuWrite;
	logic        lsuDone;
	memWidthT    lsuWidth;
	logic [31:0] lsuAddr;
	logic [31:0] lsuWdata;
	logic [31:0] lsuRdata;
	logic        dataValid;
	logic        dataReady;
	logic        dataWrite;
	logic        dataRvalid;
	logic [31:0] dataAddr;
	logic [31:0] dataWdata;
	logic [31:0] dataRdata;
	logic [3:0]  dataStrb;

	fetchUnit #(.resetPc(resetPc)) uFetch (
		.clk, .rstN, .fetchValid, .fetchAddr, .fetchReady, .fetchRvalid, .fetchRdata,
		.instrValid, .instr, .instrReady, .pc, .nextPcValid, .nextPc
	);

	controlUnit uCtrl (
		.instr, .aluOp, .immKind, .memWidth, .immSel, .setDataZero, .regWrite,
		.memRead, .memWrite(memWriteOp), .branch, .pcOperand, .jump, .linkPc4
	);

	immGen uImm (.instr, .immKind, .imm);

	execUnit uExec (
		.clk, .rstN, .instrValid, .instr, .instrReady, .aluOp, .immKind, .memWidth,
		.immSel, .setDataZero, .regWrite, .memRead, .memWrite(memWriteOp), .branch,
		.pcOperand, .jump, .linkPc4, .imm, .pc, .nextPcValid, .nextPc, .lsuValid,
		.lsuWrite, .lsuWidth, .lsuAddr, .lsuWdata, .lsuReady, .lsuDone, .lsuRdata
	);

	loadStoreUnit uLsu (
		.clk, .rstN, .lsuValid, .lsuWrite, .lsuWidth, .lsuAddr, .lsuWdata, .lsuReady,
		.lsuDone, .lsuRdata, .dataValid, .dataWrite, .dataAddr, .dataWdata, .dataStrb,
		.dataReady, .dataRvalid, .dataRdata
	);

	memArbiter uArb (
		.clk, .rstN, .fetchValid, .fetchAddr, .fetchReady, .fetchRvalid, .fetchRdata,
		.dataValid, .dataWrite, .dataAddr, .dataWdata, .dataStrb, .dataReady,
		.dataRvalid, .dataRdata, .memValid, .memWrite, .memAddr, .memWdata, .memStrb,
		.memReady, .memRvalid, .memRdata
	);

endmodule

`default_nettype wire

// ==== tbRvCore.sv ====
`timescale 1ns/100ps

module tbRvCore;
	import rvPkg::*;

	localparam logic [31:0] resetPc  = 32'h0;
	localparam logic [31:0] dataAddr = 32'h800;      // Load source word
	localparam logic [31:0] dataWord = 32'h80f1_7f92; // Mixed sign bytes and halves

	localparam int kOp     = 0;
	localparam int kOpImm  = 1;
	localparam int kLui    = 2;
	localparam int kAuipc  = 3;
	localparam int kLoad   = 4;
	localparam int kStore  = 5;
	localparam int kBranch = 6;
	localparam int kJal    = 7;
	localparam int kJalr   = 8;

	typedef struct {
		string       name;
		int          kind;
		logic [2:0]  f3;
		logic        alt;    // funct7 bit 30
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;   // Result word address
		logic [31:0] exp;
		logic [3:0]  expStrb;
	} rowT;

	logic        clk;
	logic        rstN;
	logic        memValid;
	logic        memWrite;
	logic [31:0] memAddr;
	logic [31:0] memWdata;
	logic [3:0]  memStrb;
	logic        memReady;
	logic        memRvalid;
	logic [31:0] memRdata;

	logic [31:0] mem [1024];
	rowT         rows [$];
	logic [31:0] seed = 32'h7c79_ffab;
	logic [31:0] curAddr;  // Result address of the running row
	logic        captured;
	logic [31:0] capWord;
	logic [3:0]  capStrb;
	logic        pending;
	int          latCnt;
	logic [31:0] respData;
	logic        prevWait; // Request seen waiting last cycle
	logic        prevWrite;
	logic [31:0] prevAddr;
	logic [31:0] prevWdata;
	logic [3:0]  prevStrb;
	logic        firstSeen;
	int          cycles = 0;
	int          limit = 0;
	int          errCount = 0; // Bus protocol failures
	int          passCount = 0;
	int          failCount = 0;

	rvCore #(.resetPc(resetPc)) DUT (
		.clk, .rstN, .memValid, .memWrite, .memAddr, .memWdata, .memStrb,
		.memReady, .memRvalid, .memRdata
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lcgNext();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [31:0] fillWord(int i);
		logic [31:0] w;
		w = i;
		return (w * 32'h9e37_79b1) ^ 32'h5a5a_0f0f; // Whole index mixed in
	endfunction

	function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
	endfunction

	function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
	endfunction

	function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic isReg,
			logic [31:0] a, logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			3'd0: return (isReg && alt) ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? 32'(sa >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchRef(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// Expected stored word and strobe from the RV32I rules
	task automatic expectedOf(inout rowT r);
		logic [31:0] sh;
		logic [31:0] old;
		logic [1:0]  off;
		off = r.imm[1:0];
		r.expStrb = 4'hf;
		case (r.kind)
			kOp:    r.exp = aluRef(r.f3, r.alt, 1'b1, r.a, r.b);
			kOpImm: r.exp = aluRef(r.f3, r.alt, 1'b0, r.a, {{20{r.imm[11]}}, r.imm[11:0]});
			kLui:   r.exp = {r.imm[19:0], 12'd0};
			kAuipc: r.exp = 32'd24 + {r.imm[19:0], 12'd0}; // Instruction sits at 24
			kLoad: begin
				sh = dataWord >> (8 * off);
				case (r.f3)
					3'd0: r.exp = {{24{sh[7]}}, sh[7:0]};
					3'd1: r.exp = {{16{sh[15]}}, sh[15:0]};
					3'd4: r.exp = {24'd0, sh[7:0]};
					3'd5: r.exp = {16'd0, sh[15:0]};
					default: r.exp = sh;
				endcase
			end
			kStore: begin
				old = fillWord(r.addr[11:2]);
				r.exp = old;
				case (r.f3)
					3'd0: begin
						r.exp[8*off +: 8] = r.b[7:0];
						r.expStrb = 4'b0001 << off;
					end
					3'd1: begin
						r.exp[8*off +: 16] = r.b[15:0];
						r.expStrb = 4'b0011 << off;
					end
					default: r.exp = r.b;
				endcase
			end
			kBranch: r.exp = branchRef(r.f3, r.a, r.b) ? 32'd2 : 32'd1; // Path marker
			default: r.exp = 32'd28; // Link of the jump at 24
		endcase
	endtask

	task automatic addRow(string name, int kind, logic [2:0] f3, logic alt,
			logic [31:0] a, logic [31:0] b, logic [31:0] imm);
		rowT r;
		r.name = name;
		r.kind = kind;
		r.f3   = f3;
		r.alt  = alt;
		r.a    = a;
		r.b    = b;
		r.imm  = imm;
		r.addr = 32'h400 + 4 * rows.size();
		if (kind == kStore)
			r.a = r.addr; // Store base is the result word
		expectedOf(r);
		rows.push_back(r);
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////////
	task automatic buildTable();
		string nm;
		addRow("add",   kOp, 3'd0, 1'b0, 32'h7fff_fff0, 32'h20, 0);
		addRow("sub",   kOp, 3'd0, 1'b1, 32'd5, 32'd9, 0);
		addRow("sll",   kOp, 3'd1, 1'b0, 32'h8000_0001, 32'd33, 0); // Only 5 bits count
		addRow("slt",   kOp, 3'd2, 1'b0, 32'hffff_fffd, 32'd2, 0);
		addRow("sltu",  kOp, 3'd3, 1'b0, 32'hffff_fffd, 32'd2, 0);
		addRow("xor",   kOp, 3'd4, 1'b0, 32'hf0f0_1234, 32'h0ff0_4321, 0);
		addRow("srl",   kOp, 3'd5, 1'b0, 32'hf000_0f00, 32'd4, 0);
		addRow("sra",   kOp, 3'd5, 1'b1, 32'hf000_0f00, 32'd4, 0);
		addRow("or",    kOp, 3'd6, 1'b0, 32'ha500_0050, 32'h005a_0a00, 0);
		addRow("and",   kOp, 3'd7, 1'b0, 32'hff00_ff0f, 32'h0ff0_f0ff, 0);
		addRow("addi",  kOpImm, 3'd0, 1'b0, 32'd100, 0, 32'hfff); // -1
		addRow("addi 1024", kOpImm, 3'd0, 1'b0, 32'd100, 0, 32'h400); // funct7 bits as in SUB
		addRow("slti",  kOpImm, 3'd2, 1'b0, 32'hffff_fff0, 0, 32'hff8);
		addRow("sltiu", kOpImm, 3'd3, 1'b0, 32'd7, 0, 32'hfff); // Compares to all ones
		addRow("xori",  kOpImm, 3'd4, 1'b0, 32'h1234_5678, 0, 32'h800);
		addRow("ori",   kOpImm, 3'd6, 1'b0, 32'h1000_0000, 0, 32'h0f0);
		addRow("andi",  kOpImm, 3'd7, 1'b0, 32'h8765_4321, 0, 32'h7f0);
		addRow("slli",  kOpImm, 3'd1, 1'b0, 32'h0000_0f01, 0, 32'd12);
		addRow("srli",  kOpImm, 3'd5, 1'b0, 32'h8000_0000, 0, 32'd31);
		addRow("srai",  kOpImm, 3'd5, 1'b1, 32'h8000_0000, 0, 32'd31);
		addRow("lui",   kLui, 3'd0, 1'b0, 0, 0, 32'hfedcb);
		addRow("auipc", kAuipc, 3'd0, 1'b0, 0, 0, 32'h00012);
		for (int o = 0; o < 4; o++) begin
			addRow($sformatf("lb+%0d", o), kLoad, 3'd0, 1'b0, dataAddr, 0, o);
			addRow($sformatf("lbu+%0d", o), kLoad, 3'd4, 1'b0, dataAddr, 0, o);
			addRow($sformatf("sb+%0d", o), kStore, 3'd0, 1'b0, 0, 32'h1234_56a7, o);
		end
		for (int o = 0; o < 4; o += 2) begin
			addRow($sformatf("lh+%0d", o), kLoad, 3'd1, 1'b0, dataAddr, 0, o);
			addRow($sformatf("lhu+%0d", o), kLoad, 3'd5, 1'b0, dataAddr, 0, o);
			addRow($sformatf("sh+%0d", o), kStore, 3'd1, 1'b0, 0, 32'h1234_c3d4, o);
		end
		addRow("lw", kLoad, 3'd2, 1'b0, dataAddr, 0, 0);
		addRow("sw", kStore, 3'd2, 1'b0, 0, 32'hdead_beef, 0);
		for (int f = 0; f < 8; f++) begin
			if (f == 2 || f == 3)
				continue; // No branch for these funct3
			nm = (f == 0) ? "beq" : (f == 1) ? "bne" : (f == 4) ? "blt" :
				(f == 5) ? "bge" : (f == 6) ? "bltu" : "bgeu";
			addRow({nm, " a<b"}, kBranch, f[2:0], 1'b0, 32'd1, 32'hffff_ffff, 0);
			addRow({nm, " a>b"}, kBranch, f[2:0], 1'b0, 32'hffff_ffff, 32'd1, 0);
			addRow({nm, " a=b"}, kBranch, f[2:0], 1'b0, 32'd5, 32'd5, 0);
		end
		addRow("jal",  kJal, 3'd0, 1'b0, 0, 0, 0);
		addRow("jalr", kJalr, 3'd0, 1'b0, 32'd41, 0, 0); // Bit 0 must be dropped
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Program builder
	//////////////////////////////////////////////////////////////////////////
	task automatic putConst(logic [31:0] pcAddr, logic [4:0] rd, logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800; // ADDI sign-extends the low part
		mem[pcAddr[11:2]]     = {hi[31:12], rd, opLui};
		mem[pcAddr[11:2] + 1] = encI(v[11:0], rd, 3'd0, rd, opImm);
	endtask

	task automatic loadProgram(rowT r);
		logic [31:0] ut;
		logic [11:0] iField;
		logic        ctrlFlow;
		for (int i = 0; i < 1024; i++)
			mem[i] = fillWord(i);
		mem[dataAddr[11:2]] = dataWord;
		putConst(0, 5'd1, r.a);
		putConst(8, 5'd2, r.b);
		putConst(16, 5'd4, r.addr);
		iField = (r.f3 == 3'd1 || r.f3 == 3'd5) ? {1'b0, r.alt, 5'd0, r.imm[4:0]} : r.imm[11:0];
		case (r.kind)
			kOp:     ut = encR({1'b0, r.alt, 5'd0}, 5'd2, 5'd1, r.f3, 5'd3);
			kOpImm:  ut = encI(iField, 5'd1, r.f3, 5'd3, opImm);
			kLui:    ut = {r.imm[19:0], 5'd3, opLui};
			kAuipc:  ut = {r.imm[19:0], 5'd3, opAuipc};
			kLoad:   ut = encI(r.imm[11:0], 5'd1, r.f3, 5'd3, opLoad);
			kStore:  ut = encS(r.imm[11:0], 5'd2, 5'd1, r.f3);
			kBranch: ut = encB(13'd12, 5'd2, 5'd1, r.f3); // To 36
			kJal:    ut = encJ(21'd16, 5'd3);             // To 40
			default: ut = encI(12'd0, 5'd1, 3'd0, 5'd3, opJalr);
		endcase
		ctrlFlow = r.kind == kBranch || r.kind == kJal || r.kind == kJalr;
		mem[6]  = ut;                                        // PC 24
		mem[7]  = ctrlFlow ? encI(12'd1, 5'd0, 3'd0, 5'd3, opImm) : encI(0, 0, 0, 0, opImm);
		mem[8]  = ctrlFlow ? encJ(21'd8, 5'd0) : encI(0, 0, 0, 0, opImm);
		mem[9]  = ctrlFlow ? encI(12'd2, 5'd0, 3'd0, 5'd3, opImm) : encI(0, 0, 0, 0, opImm);
		mem[10] = encS(12'd0, 5'd3, 5'd4, 3'd2);             // SW x3, 0(x4)
		mem[11] = encJ(21'd0, 5'd0);                         // Park here
	endtask

	//////////////////////////////////////////////////////////////////////////
	// Memory bus model
	//////////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (!rstN) begin
			pending   = 1'b0;
			memReady  = 1'b0;
			memRvalid = 1'b0;
			memRdata  = 32'd0;
			prevWait  = 1'b0;
			firstSeen = 1'b0;
			if (memValid) begin
				$display("memValid went high during reset");
				errCount++;
			end
		end else begin
			memRvalid = 1'b0;
			memRdata  = 32'd0;
			if (pending) begin
				memReady = 1'b0;
				if (latCnt == 1) begin
					memRvalid = 1'b1; // One response per request
					memRdata  = respData;
					pending   = 1'b0;
				end else
					latCnt--;
			end else
				memReady = ((lcgNext() >> 16) % 4) != 0;
			#1;
			if (rstN) begin
				if (prevWait && (!memValid || memWrite != prevWrite || memAddr != prevAddr ||
						memWdata != prevWdata || memStrb != prevStrb)) begin
					$display("bus request changed while waiting at %h", prevAddr);
					errCount++;
				end
				if (memValid && !firstSeen) begin
					firstSeen = 1'b1;
					if (memWrite || memAddr != resetPc) begin
						$display("first request after reset was not a fetch from resetPc");
						errCount++;
					end
				end
				if (memValid && memReady) begin
					if (memAddr[1:0] != 2'b00) begin
						$display("bus address %h is not word aligned", memAddr);
						errCount++;
					end
					pending  = 1'b1;
					latCnt   = 1 + ((lcgNext() >> 16) % 3);
					respData = mem[memAddr[11:2]];
					if (memWrite) begin
						for (int l = 0; l < 4; l++)
							if (memStrb[l])
								mem[memAddr[11:2]][8*l +: 8] = memWdata[8*l +: 8];
						if (memAddr == {curAddr[31:2], 2'b00} && !captured) begin
							captured = 1'b1;
							capWord  = mem[memAddr[11:2]];
							capStrb  = memStrb;
						end
					end
				end
				prevWait  = memValid && !memReady;
				prevWrite = memWrite;
				prevAddr  = memAddr;
				prevWdata = memWdata;
				prevStrb  = memStrb;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, a result store never appeared", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////////
	initial begin
		rstN      = 1'b0;
		memReady  = 1'b0;
		memRvalid = 1'b0;
		memRdata  = 32'd0;
		captured  = 1'b0;
		curAddr   = 32'd0;
		buildTable();
		limit = rows.size() * 200;
		foreach (rows[i]) begin
			@(negedge clk);
			rstN = 1'b0;
			loadProgram(rows[i]);
			curAddr  = rows[i].addr;
			captured = 1'b0;
			repeat (4) @(negedge clk); // Reset held 4 cycles
			rstN = 1'b1;
			while (!captured)
				@(negedge clk);
			if (capWord != rows[i].exp) begin
				$display("error %s expected %h actual %h", rows[i].name, rows[i].exp, capWord);
				failCount++;
			end else if (capStrb != rows[i].expStrb) begin
				$display("error %s strobe expected %b actual %b", rows[i].name,
					rows[i].expStrb, capStrb);
				failCount++;
			end else begin
				$display("pass %s %h", rows[i].name, capWord);
				passCount++;
			end
		end
		$display("%0d tests, %0d passed, %0d failed, %0d bus errors", rows.size(),
			passCount, failCount, errCount);
		if (failCount == 0 && errCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
rvPkg.sv
controlUnit.sv
immGen.sv
execUnit.sv
fetchUnit.sv
loadStoreUnit.sv
memArbiter.sv
rvCore.sv
tbRvCore.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tbRvCore -f sources.f
./obj_dir/VtbRvCore | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
grep -q "SIMULATION PASSED" sim.log
